//--- src/l1b_params.svh
`ifndef L1B_PARAMS_SVH
`define L1B_PARAMS_SVH

// Adres ve veri genislikleri
`define ADRES_BIT           32
`define VERI_BIT            32

// Blok dort kelime
`define L1_BLOK_BIT         128
`define BLOK_KELIME         4

// Adres alanlari: etiket | satir | bayt
`define ADRES_BYTE_BIT      4
`define ADRES_SATIR_BIT     4
`define ADRES_ETIKET_BIT    24

// Onbellek duzeni
`define L1B_SATIR           16
`define L1B_YOL             2

`endif

//--- src/l1b_pkg.sv
`include "l1b_params.svh"

package l1b_pkg;

    // Adresin alan gorunumu
    typedef struct packed {
        logic [`ADRES_ETIKET_BIT-1:0] etiket;
        logic [`ADRES_SATIR_BIT-1:0]  satir;
        logic [`ADRES_BYTE_BIT-1:0]   bayt;
    } adres_alan_t;

    // Yolda duz, arama sirasinda alanlara ayrilmis okunur
    typedef union packed {
        logic [`ADRES_BIT-1:0] duz;
        adres_alan_t           alan;
    } adres_t;

    typedef struct packed {
        logic [`ADRES_ETIKET_BIT-1:0] etiket;
        logic [`L1_BLOK_BIT-1:0]      blok;
    } yol_t;

    typedef struct packed {
        logic                        gecerli;
        logic [`ADRES_SATIR_BIT-1:0] satir;
        logic [`L1B_YOL-1:0]         yaz;
        yol_t [`L1B_YOL-1:0]         yol;
    } bellek_istek_t;

    typedef struct packed {
        yol_t [`L1B_YOL-1:0] yol;
    } bellek_yanit_t;

    typedef struct packed {
        adres_t adres;
    } vy_istek_t;

endpackage

//--- src/l1b_denetleyici.sv
`timescale 1ns/1ns

`include "l1b_params.svh"

module l1b_denetleyici (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  l1b_pkg::adres_t         port_istek_adres_i,
    input  logic                    port_istek_gecerli_i,
    output logic                    port_istek_hazir_o,

    output logic [`VERI_BIT-1:0]    port_veri_o,
    output logic                    port_veri_gecerli_o,
    input  logic                    port_veri_hazir_i,

    output l1b_pkg::bellek_istek_t  bellek_istek_o,
    input  l1b_pkg::bellek_yanit_t  bellek_yanit_i,

    output l1b_pkg::vy_istek_t      vy_istek_o,
    output logic                    vy_istek_gecerli_o,
    input  logic                    vy_istek_hazir_i,

    input  logic [`L1_BLOK_BIT-1:0] vy_veri_i,
    input  logic                    vy_veri_gecerli_i,
    output logic                    vy_veri_hazir_o
);
    import l1b_pkg::*;

    localparam int YOL_IDX_BIT    = $clog2(`L1B_YOL);
    localparam int KELIME_IDX_BIT = $clog2(`BLOK_KELIME);

    typedef enum logic [1:0] {BOSTA, VY_ISTEK, VY_BEKLE, VY_YAZ} durum_t;

    durum_t                     durum_r;
    durum_t                     durum_ns;
    adres_t                     son_adres_r;
    adres_t                     son_adres_ns;
    logic                       son_gecerli_r;
    logic                       son_gecerli_ns;
    logic                       tut_gecerli_r;
    logic                       tut_gecerli_ns;
    logic [`VERI_BIT-1:0]       tut_veri_r;
    logic [`VERI_BIT-1:0]       tut_veri_ns;
    logic [YOL_IDX_BIT-1:0]     hedef_yol_r;
    logic [YOL_IDX_BIT-1:0]     hedef_yol_ns;
    logic                       vy_istek_gecerli_r;
    logic                       vy_istek_gecerli_ns;
    logic                       vy_veri_hazir_r;
    logic                       vy_veri_hazir_ns;
    logic [`L1B_YOL-1:0]        satir_gecerli_r [`L1B_SATIR];
    logic [YOL_IDX_BIT-1:0]     kurban_r;

    logic [`L1B_YOL-1:0]        acik_gecerli;
    logic                       isabet;
    logic [YOL_IDX_BIT-1:0]     isabet_yol;
    logic [YOL_IDX_BIT-1:0]     bos_yol;
    logic [KELIME_IDX_BIT-1:0]  kelime_idx;
    logic [`VERI_BIT-1:0]       isabet_veri;
    logic                       dolum_bitti;

    assign vy_istek_gecerli_o = vy_istek_gecerli_r;
    assign vy_veri_hazir_o    = vy_veri_hazir_r;
    assign vy_istek_o.adres.duz = {son_adres_r.duz[`ADRES_BIT-1:`ADRES_BYTE_BIT],
                                   {`ADRES_BYTE_BIT{1'b0}}};

    assign acik_gecerli = satir_gecerli_r[son_adres_r.alan.satir];
    assign kelime_idx   = son_adres_r.alan.bayt[`ADRES_BYTE_BIT-1 -: KELIME_IDX_BIT];
    assign isabet_veri  = bellek_yanit_i.yol[isabet_yol].blok[kelime_idx * `VERI_BIT +: `VERI_BIT];
    assign dolum_bitti  = (durum_r == VY_BEKLE) && vy_veri_hazir_r && vy_veri_gecerli_i;

    // Etiket karsilastirma ve kurban secimi
    always_comb begin
        isabet     = 1'b0;
        isabet_yol = '0;
        bos_yol    = kurban_r;
        for (int y = `L1B_YOL - 1; y >= 0; y--) begin
            if (acik_gecerli[y] && bellek_yanit_i.yol[y].etiket == son_adres_r.alan.etiket) begin
                isabet     = 1'b1;
                isabet_yol = YOL_IDX_BIT'(y);
            end
            // En dusuk numarali gecersiz yol kazanir
            if (!acik_gecerli[y]) begin
                bos_yol = YOL_IDX_BIT'(y);
            end
        end
    end

    always_comb begin
        durum_ns            = durum_r;
        son_adres_ns        = son_adres_r;
        son_gecerli_ns      = 1'b0;
        tut_gecerli_ns      = tut_gecerli_r;
        tut_veri_ns         = tut_veri_r;
        hedef_yol_ns        = hedef_yol_r;
        vy_istek_gecerli_ns = vy_istek_gecerli_r;
        vy_veri_hazir_ns    = vy_veri_hazir_r;
        port_istek_hazir_o  = 1'b0;
        port_veri_o         = tut_veri_r;
        port_veri_gecerli_o = tut_gecerli_r;
        bellek_istek_o.gecerli = 1'b0;
        bellek_istek_o.satir   = son_adres_r.alan.satir;
        bellek_istek_o.yaz     = '0;
        for (int y = 0; y < `L1B_YOL; y++) begin
            bellek_istek_o.yol[y].etiket = son_adres_r.alan.etiket;
            bellek_istek_o.yol[y].blok   = vy_veri_i;
        end

        case (durum_r)
            BOSTA: begin
                if (tut_gecerli_r) begin
                    if (port_veri_hazir_i) begin
                        tut_gecerli_ns     = 1'b0;
                        port_istek_hazir_o = 1'b1;
                    end
                end else if (son_gecerli_r && !isabet) begin
                    hedef_yol_ns        = bos_yol;
                    vy_istek_gecerli_ns = 1'b1;
                    durum_ns            = VY_ISTEK;
                end else if (son_gecerli_r) begin
                    port_veri_o         = isabet_veri;
                    port_veri_gecerli_o = 1'b1;
                    if (port_veri_hazir_i) begin
                        port_istek_hazir_o = 1'b1;
                    end else begin
                        tut_gecerli_ns = 1'b1;
                        tut_veri_ns    = isabet_veri;
                    end
                end else begin
                    port_istek_hazir_o = 1'b1;
                end
                // Yeni istek ayni cevrimde bellege gider
                if (port_istek_hazir_o && port_istek_gecerli_i) begin
                    bellek_istek_o.gecerli = 1'b1;
                    bellek_istek_o.satir   = port_istek_adres_i.alan.satir;
                    son_adres_ns           = port_istek_adres_i;
                    son_gecerli_ns         = 1'b1;
                end
            end
            VY_ISTEK: begin
                if (vy_istek_hazir_i) begin
                    vy_istek_gecerli_ns = 1'b0;
                    vy_veri_hazir_ns    = 1'b1;
                    durum_ns            = VY_BEKLE;
                end
            end
            VY_BEKLE: begin
                if (dolum_bitti) begin
                    bellek_istek_o.yaz[hedef_yol_r] = 1'b1;
                    vy_veri_hazir_ns = 1'b0;
                    durum_ns         = VY_YAZ;
                end
            end
            default: begin
                // Satiri yeniden oku, isabet yolu yaniti verir
                bellek_istek_o.gecerli = 1'b1;
                son_gecerli_ns         = 1'b1;
                durum_ns               = BOSTA;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            durum_r            <= BOSTA;
            son_gecerli_r      <= 1'b0;
            tut_gecerli_r      <= 1'b0;
            vy_istek_gecerli_r <= 1'b0;
            vy_veri_hazir_r    <= 1'b0;
            kurban_r           <= '0;
            for (int s = 0; s < `L1B_SATIR; s++) begin
                satir_gecerli_r[s] <= '0;
            end
        end else begin
            durum_r            <= durum_ns;
            son_gecerli_r      <= son_gecerli_ns;
            tut_gecerli_r      <= tut_gecerli_ns;
            vy_istek_gecerli_r <= vy_istek_gecerli_ns;
            vy_veri_hazir_r    <= vy_veri_hazir_ns;
            if (dolum_bitti) begin
                satir_gecerli_r[son_adres_r.alan.satir][hedef_yol_r] <= 1'b1;
                kurban_r <= kurban_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        son_adres_r <= son_adres_ns;
        tut_veri_r  <= tut_veri_ns;
        hedef_yol_r <= hedef_yol_ns;
    end

    a_vy_istek_kararli: assert property (@(posedge clk_i) disable iff (!rstn_i)
        vy_istek_gecerli_o && !vy_istek_hazir_i |=> vy_istek_gecerli_o && $stable(vy_istek_o));

    a_tek_yol_yaz: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(bellek_istek_o.yaz));

endmodule

//--- src/l1b_bellek.sv
`timescale 1ns/1ns

`include "l1b_params.svh"

module l1b_bellek (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  l1b_pkg::bellek_istek_t istek_i,
    output l1b_pkg::bellek_yanit_t yanit_o
);
    import l1b_pkg::*;

    // Her yol ayri bir blok RAM
    for (genvar y = 0; y < `L1B_YOL; y++) begin : g_yol
        logic [`ADRES_ETIKET_BIT-1:0] etiket_mem [`L1B_SATIR];
        logic [`L1_BLOK_BIT-1:0]      blok_mem [`L1B_SATIR];
        yol_t                         okunan_r;

        always_ff @(posedge clk_i) begin
            if (istek_i.yaz[y]) begin
                etiket_mem[istek_i.satir] <= istek_i.yol[y].etiket;
                blok_mem[istek_i.satir]   <= istek_i.yol[y].blok;
            end
            if (istek_i.gecerli) begin
                okunan_r.etiket <= etiket_mem[istek_i.satir];
                okunan_r.blok   <= blok_mem[istek_i.satir];
            end
        end

        assign yanit_o.yol[y] = okunan_r;
    end

    // Denetleyici okuma ile yazmayi ayni cevrime koymaz
    a_oku_yaz_ayri: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(istek_i.gecerli && |istek_i.yaz));

endmodule

//--- src/veri_yolu_denetleyici.sv
`timescale 1ns/1ns

`include "l1b_params.svh"

module veri_yolu_denetleyici (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  l1b_pkg::vy_istek_t      vy_istek_i,
    input  logic                    vy_istek_gecerli_i,
    output logic                    vy_istek_hazir_o,

    output logic [`L1_BLOK_BIT-1:0] vy_veri_o,
    output logic                    vy_veri_gecerli_o,
    input  logic                    vy_veri_hazir_i,

    output logic                    bellek_req_o,
    input  logic                    bellek_ack_i,
    output l1b_pkg::adres_t         bellek_adres_o,
    input  logic [`VERI_BIT-1:0]    bellek_veri_i
);
    import l1b_pkg::*;

    localparam int KELIME_IDX_BIT = $clog2(`BLOK_KELIME);

    typedef enum logic [1:0] {BOSTA, ISTEK, BIRAK, SUN} durum_t;

    durum_t                    durum_r;
    logic [KELIME_IDX_BIT-1:0] kelime_r;
    logic                      req_r;
    adres_t                    blok_adres_r;
    logic [`L1_BLOK_BIT-1:0]   blok_r;

    assign vy_istek_hazir_o  = (durum_r == BOSTA);
    assign vy_veri_gecerli_o = (durum_r == SUN);
    assign vy_veri_o         = blok_r;
    assign bellek_req_o      = req_r;
    assign bellek_adres_o.duz = {blok_adres_r.duz[`ADRES_BIT-1:`ADRES_BYTE_BIT], kelime_r,
                                 {(`ADRES_BYTE_BIT - KELIME_IDX_BIT){1'b0}}};

    // Dort fazli el sikisma, blok basina dort kelime
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            durum_r  <= BOSTA;
            kelime_r <= '0;
            req_r    <= 1'b0;
        end else begin
            case (durum_r)
                BOSTA: begin
                    if (vy_istek_gecerli_i) begin
                        kelime_r <= '0;
                        req_r    <= 1'b1;
                        durum_r  <= ISTEK;
                    end
                end
                ISTEK: begin
                    if (bellek_ack_i) begin
                        req_r   <= 1'b0;
                        durum_r <= BIRAK;
                    end
                end
                BIRAK: begin
                    // ack dusmeden yeni req yok
                    if (!bellek_ack_i) begin
                        if (kelime_r == KELIME_IDX_BIT'(`BLOK_KELIME - 1)) begin
                            durum_r <= SUN;
                        end else begin
                            kelime_r <= kelime_r + 1'b1;
                            req_r    <= 1'b1;
                            durum_r  <= ISTEK;
                        end
                    end
                end
                default: begin
                    if (vy_veri_hazir_i) begin
                        durum_r <= BOSTA;
                    end
                end
            endcase
        end
    end

    // Kelime k, blogun 32k bitine kayar
    always_ff @(posedge clk_i) begin
        if (durum_r == BOSTA && vy_istek_gecerli_i) begin
            blok_adres_r <= vy_istek_i.adres;
        end
        if (durum_r == ISTEK && bellek_ack_i) begin
            blok_r <= {bellek_veri_i, blok_r[`L1_BLOK_BIT-1:`VERI_BIT]};
        end
    end

    a_req_ack_dusuk: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(bellek_req_o) |-> !$past(bellek_ack_i));

endmodule

//--- src/l1b_alt_sistem.sv
`timescale 1ns/1ns

`include "l1b_params.svh"

module l1b_alt_sistem (
    input  logic                 clk_i,
    input  logic                 rstn_i,

    input  l1b_pkg::adres_t      port_istek_adres_i,
    input  logic                 port_istek_gecerli_i,
    output logic                 port_istek_hazir_o,

    output logic [`VERI_BIT-1:0] port_veri_o,
    output logic                 port_veri_gecerli_o,
    input  logic                 port_veri_hazir_i,

    output logic                 bellek_req_o,
    input  logic                 bellek_ack_i,
    output l1b_pkg::adres_t      bellek_adres_o,
    input  logic [`VERI_BIT-1:0] bellek_veri_i
);
    import l1b_pkg::*;

    bellek_istek_t           bellek_istek;
    bellek_yanit_t           bellek_yanit;
    vy_istek_t               vy_istek;
    logic                    vy_istek_gecerli;
    logic                    vy_istek_hazir;
    logic [`L1_BLOK_BIT-1:0] vy_veri;
    logic                    vy_veri_gecerli;
    logic                    vy_veri_hazir;

    l1b_denetleyici i_l1b_denetleyici (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .port_istek_adres_i   (port_istek_adres_i),
        .port_istek_gecerli_i (port_istek_gecerli_i),
        .port_istek_hazir_o   (port_istek_hazir_o),
        .port_veri_o          (port_veri_o),
        .port_veri_gecerli_o  (port_veri_gecerli_o),
        .port_veri_hazir_i    (port_veri_hazir_i),
        .bellek_istek_o       (bellek_istek),
        .bellek_yanit_i       (bellek_yanit),
        .vy_istek_o           (vy_istek),
        .vy_istek_gecerli_o   (vy_istek_gecerli),
        .vy_istek_hazir_i     (vy_istek_hazir),
        .vy_veri_i            (vy_veri),
        .vy_veri_gecerli_i    (vy_veri_gecerli),
        .vy_veri_hazir_o      (vy_veri_hazir)
    );

    l1b_bellek i_l1b_bellek (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .istek_i (bellek_istek),
        .yanit_o (bellek_yanit)
    );

    veri_yolu_denetleyici i_veri_yolu_denetleyici (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .vy_istek_i         (vy_istek),
        .vy_istek_gecerli_i (vy_istek_gecerli),
        .vy_istek_hazir_o   (vy_istek_hazir),
        .vy_veri_o          (vy_veri),
        .vy_veri_gecerli_o  (vy_veri_gecerli),
        .vy_veri_hazir_i    (vy_veri_hazir),
        .bellek_req_o       (bellek_req_o),
        .bellek_ack_i       (bellek_ack_i),
        .bellek_adres_o     (bellek_adres_o),
        .bellek_veri_i      (bellek_veri_i)
    );

endmodule

//--- sim/tb_l1b_alt_sistem.sv
`timescale 1ns/1ns

`include "l1b_params.svh"

module tb_l1b_alt_sistem;
    import l1b_pkg::*;

    logic                         clk_i = 1'b0;
    logic                         rstn_i;
    adres_t                       port_istek_adres_i;
    logic                         port_istek_gecerli_i;
    logic                         port_istek_hazir_o;
    logic [`VERI_BIT-1:0]         port_veri_o;
    logic                         port_veri_gecerli_o;
    logic                         port_veri_hazir_i;
    logic                         bellek_req_o;
    logic                         bellek_ack_i;
    adres_t                       bellek_adres_o;
    logic [`VERI_BIT-1:0]         bellek_veri_i;

    logic [31:0]                  lfsr_r = 32'h8b08110b;
    int                           istek_sayisi = 0;
    adres_t                       istek_adresleri [$];
    int                           verilen_istek = 0;
    int                           cevrim = 0;

    // Basvuru modeli: gecerli bitler, etiketler, kurban sayaci
    logic                         model_gecerli [`L1B_SATIR][`L1B_YOL];
    logic [`ADRES_ETIKET_BIT-1:0] model_etiket [`L1B_SATIR][`L1B_YOL];
    int                           model_kurban;

    l1b_alt_sistem i_l1b_alt_sistem (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .port_istek_adres_i   (port_istek_adres_i),
        .port_istek_gecerli_i (port_istek_gecerli_i),
        .port_istek_hazir_o   (port_istek_hazir_o),
        .port_veri_o          (port_veri_o),
        .port_veri_gecerli_o  (port_veri_gecerli_o),
        .port_veri_hazir_i    (port_veri_hazir_i),
        .bellek_req_o         (bellek_req_o),
        .bellek_ack_i         (bellek_ack_i),
        .bellek_adres_o       (bellek_adres_o),
        .bellek_veri_i        (bellek_veri_i)
    );

    always #5 clk_i = ~clk_i;

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_adim();
        logic geri;
        geri   = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
        lfsr_r = {lfsr_r[30:0], geri};
        return geri;
    endfunction

    function automatic logic [31:0] rastgele_al(input int bit_sayisi);
        logic [31:0] deger;
        deger = '0;
        for (int i = 0; i < bit_sayisi; i++) begin
            deger = {deger[30:0], lfsr_adim()};
        end
        return deger;
    endfunction

    task automatic kelime_karsilastir(input string ad, input logic [`VERI_BIT-1:0] gercek,
                                      input logic [`VERI_BIT-1:0] beklenen);
        if (gercek !== beklenen) begin
            $display("Error: time %0t, %s got %h expected %h", $time, ad, gercek, beklenen);
            $display("tests failed");
            $fatal(1, "Data word mismatch on %s", ad);
        end
    endtask

    task automatic sayac_karsilastir(input string ad, input int gercek, input int beklenen);
        if (gercek != beklenen) begin
            $display("Error: time %0t, %s got %0d expected %0d", $time, ad, gercek, beklenen);
            $display("tests failed");
            $fatal(1, "Count mismatch on %s", ad);
        end
    endtask

    task automatic adres_karsilastir(input string ad, input adres_t gercek,
                                     input adres_t beklenen);
        if (gercek.duz !== beklenen.duz) begin
            $display("Error: time %0t, %s got %h expected %h", $time, ad, gercek.duz,
                     beklenen.duz);
            $display("tests failed");
            $fatal(1, "Address mismatch on %s", ad);
        end
    endtask

    task automatic bayrak_karsilastir(input string ad, input logic gercek, input logic beklenen);
        if (gercek !== beklenen) begin
            $display("Error: time %0t, %s got %b expected %b", $time, ad, gercek, beklenen);
            $display("tests failed");
            $fatal(1, "Flag mismatch on %s", ad);
        end
    endtask

    // Isabette 0, iskada blok basina istek sayisi doner
    function automatic int model_guncelle(input adres_t adres);
        int hedef;
        hedef = -1;
        for (int y = 0; y < `L1B_YOL; y++) begin
            if (model_gecerli[adres.alan.satir][y] &&
                model_etiket[adres.alan.satir][y] == adres.alan.etiket) begin
                return 0;
            end
        end
        for (int y = `L1B_YOL - 1; y >= 0; y--) begin
            if (!model_gecerli[adres.alan.satir][y]) begin
                hedef = y;
            end
        end
        if (hedef < 0) begin
            hedef = model_kurban;
        end
        model_gecerli[adres.alan.satir][hedef] = 1'b1;
        model_etiket[adres.alan.satir][hedef]  = adres.alan.etiket;
        model_kurban = (model_kurban + 1) % `L1B_YOL;
        return `BLOK_KELIME;
    endfunction

    // Dort fazli bellek, 0..3 cevrim gecikme
    initial begin
        int gecikme;
        bellek_ack_i  = 1'b0;
        bellek_veri_i = '0;
        forever begin
            @(negedge clk_i);
            if (bellek_req_o) begin
                gecikme = int'(rastgele_al(2));
                repeat (gecikme) @(posedge clk_i);
                @(posedge clk_i);
                #1;
                bellek_veri_i = bellek_adres_o.duz ^ 32'h5a5a0000;
                bellek_ack_i  = 1'b1;
                istek_adresleri.push_back(bellek_adres_o);
                istek_sayisi++;
                @(negedge clk_i);
                while (bellek_req_o) @(negedge clk_i);
                @(posedge clk_i);
                #1;
                bellek_ack_i = 1'b0;
            end
        end
    end

    // Negatif beklenen istek sayisi modelin tahminini kullanir
    task automatic getir(input adres_t adres, input int beklenen, input int bekletme);
        int                   onceki;
        int                   gecikme;
        int                   istek_beklenen;
        logic [`VERI_BIT-1:0] ilk_veri;
        adres_t               blok_adres;
        istek_beklenen = model_guncelle(adres);
        if (beklenen >= 0) begin
            istek_beklenen = beklenen;
        end
        onceki = istek_sayisi;
        verilen_istek++;
        @(posedge clk_i);
        #1;
        port_istek_adres_i   = adres;
        port_istek_gecerli_i = 1'b1;
        port_veri_hazir_i    = (bekletme == 0);
        @(negedge clk_i);
        while (!port_istek_hazir_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        port_istek_gecerli_i = 1'b0;
        gecikme = 1;
        @(negedge clk_i);
        while (!port_veri_gecerli_o) begin
            @(negedge clk_i);
            gecikme++;
        end
        if (istek_beklenen == 0) begin
            sayac_karsilastir("port_veri_gecerli_o latency", gecikme, 1);
        end
        ilk_veri = port_veri_o;
        kelime_karsilastir("port_veri_o", ilk_veri, adres.duz ^ 32'h5a5a0000);
        for (int k = 0; k < bekletme; k++) begin
            kelime_karsilastir("port_veri_o", port_veri_o, ilk_veri);
            bayrak_karsilastir("port_veri_gecerli_o", port_veri_gecerli_o, 1'b1);
            bayrak_karsilastir("port_istek_hazir_o", port_istek_hazir_o, 1'b0);
            @(posedge clk_i);
            #1;
            if (k == bekletme - 1) begin
                port_veri_hazir_i = 1'b1;
            end
            @(negedge clk_i);
        end
        kelime_karsilastir("port_veri_o", port_veri_o, ilk_veri);
        bayrak_karsilastir("port_veri_gecerli_o", port_veri_gecerli_o, 1'b1);
        @(posedge clk_i);
        sayac_karsilastir("bellek_req_o count", istek_sayisi - onceki, istek_beklenen);
        if (istek_beklenen == `BLOK_KELIME) begin
            for (int k = 0; k < `BLOK_KELIME; k++) begin
                blok_adres.duz = {adres.duz[`ADRES_BIT-1:`ADRES_BYTE_BIT],
                                  {`ADRES_BYTE_BIT{1'b0}}} + 32'(k * 4);
                adres_karsilastir("bellek_adres_o", istek_adresleri[onceki + k], blok_adres);
            end
        end
    endtask

    task automatic soguk_iska();
        getir(32'h00123454, 4, 0);
    endtask

    task automatic ayni_blok_isabet();
        getir(32'h00123450, 0, 0);
        getir(32'h00123458, 0, 0);
        getir(32'h0012345c, 0, 0);
    endtask

    // Satir 5, iki farkli etiket
    task automatic iki_yol_yerlesik();
        getir(32'h00abcd58, 4, 0);
        getir(32'h00123454, 0, 0);
        getir(32'h00abcd58, 0, 0);
    endtask

    // Iki dolumdan sonra sayac 0, yol 0 gider
    task automatic yer_degistirme();
        getir(32'h00777750, 4, 0);
        getir(32'h00abcd58, 0, 0);
        getir(32'h00123454, 4, 0);
    endtask

    task automatic geri_basinc();
        getir(32'h0012345c, 0, 4);
        getir(32'h00abcd58, 4, 2);
    endtask

    task automatic rastgele_adresler(input int adet);
        adres_t      adres;
        logic [31:0] r;
        for (int i = 0; i < adet; i++) begin
            r = rastgele_al(6);
            adres.alan.etiket = {22'h03f0c1, r[1:0]};
            adres.alan.satir  = {2'b00, r[3:2]};
            adres.alan.bayt   = {r[5:4], 2'b00};
            getir(adres, -1, 0);
        end
    endtask

    initial begin
        while (cevrim <= 40 * verilen_istek + 1000) begin
            @(posedge clk_i);
            cevrim++;
        end
        $display("tests failed");
        $fatal(1, "Watchdog expired, the DUT stopped making progress");
    end

    initial begin
        rstn_i               = 1'b0;
        port_istek_adres_i   = '0;
        port_istek_gecerli_i = 1'b0;
        port_veri_hazir_i    = 1'b1;
        model_kurban         = 0;
        for (int s = 0; s < `L1B_SATIR; s++) begin
            for (int y = 0; y < `L1B_YOL; y++) begin
                model_gecerli[s][y] = 1'b0;
                model_etiket[s][y]  = '0;
            end
        end
        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        @(negedge clk_i);
        bayrak_karsilastir("port_veri_gecerli_o", port_veri_gecerli_o, 1'b0);
        bayrak_karsilastir("bellek_req_o", bellek_req_o, 1'b0);
        bayrak_karsilastir("port_istek_hazir_o", port_istek_hazir_o, 1'b1);
        soguk_iska();
        ayni_blok_isabet();
        iki_yol_yerlesik();
        yer_degistirme();
        geri_basinc();
        rastgele_adresler(48);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- files.f
+incdir+src
src/l1b_pkg.sv
src/l1b_denetleyici.sv
src/l1b_bellek.sv
src/veri_yolu_denetleyici.sv
src/l1b_alt_sistem.sv
sim/tb_l1b_alt_sistem.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f \
    --top-module tb_l1b_alt_sistem -o tb_l1b_alt_sistem \
    && ./obj_dir/tb_l1b_alt_sistem \
    || exit 1
